// File: bench/cpuChecker.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuChecker #(
	parameter int NUM_STORES = 1,
	parameter int NAME_W = 128
) (
	input logic clk,
	input logic rstN,
	input cpuPkg::addrT pc,
	input logic memWrite,
	input cpuPkg::addrT memAddr,
	input cpuPkg::wordT memWData,
	input logic [NAME_W+`ADDR_W+`WORD_W-1:0] expTab [NUM_STORES],
	output int errCount,
	output int seenCount
);

	// One expected store, same layout as in the bench table.
	typedef struct packed {
		logic [NAME_W-1:0] name; // Test name, right aligned text.
		cpuPkg::addrT addr;
		cpuPkg::wordT data;
	} storeT;

	int storeErrs; // Faults seen on the store port.
	int resetErrs; // Faults seen while reset is held.
	storeT cur;

	assign errCount = storeErrs + resetErrs;

	// Drops the leading null bytes of a packed name.
	function automatic string nameOf(input logic [NAME_W-1:0] v);
		string s;
		logic [7:0] ch;
		s = "";
		for (int i = NAME_W / 8 - 1; i >= 0; i--) begin
			ch = v[i*8 +: 8];
			if (ch != 8'h00) begin
				s = $sformatf("%s%c", s, ch);
			end
		end
		return s;
	endfunction

	initial begin
		storeErrs = 0;
		resetErrs = 0;
		seenCount = 0;
	end

	// Store port is sampled at the edge where the write lands.
	always @(posedge clk) begin
		if (!rstN) begin
			if (memWrite !== 1'b0) begin
				storeErrs = storeErrs + 1;
				$display("memWrite was active while reset was held");
			end
		end else if (memWrite === 1'b1) begin
			if (seenCount >= NUM_STORES) begin
				storeErrs = storeErrs + 1; // More stores than the table lists.
				$display("unexpected extra store to %h with data %h", memAddr, memWData);
			end else begin
				cur = expTab[seenCount];
				if (memAddr !== cur.addr || memWData !== cur.data) begin
					storeErrs = storeErrs + 1;
					$display("mismatch %s: expected %h@%h, actual %h@%h",
						nameOf(cur.name), cur.data, cur.addr, memWData, memAddr);
				end
				seenCount = seenCount + 1;
			end
		end else if (memWrite !== 1'b0) begin
			storeErrs = storeErrs + 1;
			$display("memWrite is unknown at pc %h", pc);
		end
	end

	// pc settles after the first reset edge.
	always @(negedge clk) begin
		if (!rstN && pc !== '0) begin
			resetErrs = resetErrs + 1;
			$display("mismatch reset_pc: expected %h, actual %h", 8'h00, pc);
		end
	end

endmodule

// File: bench/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuTb;

	localparam int NUM_STORES = 29; // Stores the program must produce.
	localparam int NAME_W = 128; // Up to 16 characters per test name.
	localparam int STORE_W = NAME_W + `ADDR_W + `WORD_W;

	logic clk;
	logic rstN;
	cpuPkg::instrT instr;
	cpuPkg::addrT pc;
	logic memWrite;
	cpuPkg::addrT memAddr;
	cpuPkg::wordT memWData;

	cpuPkg::instrT prog [256]; // Program memory image.
	logic [STORE_W-1:0] expTab [NUM_STORES]; // Name, address, data.
	int progLen;
	int nExp;
	logic tableReady;
	int errCount;
	int seenCount;
	int missing;
	longint timeoutNs;

	cpuCore i_cpuCore (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWData(memWData)
	);

	cpuChecker #(.NUM_STORES(NUM_STORES), .NAME_W(NAME_W)) i_cpuChecker (
		.clk(clk),
		.rstN(rstN),
		.pc(pc),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWData(memWData),
		.expTab(expTab),
		.errCount(errCount),
		.seenCount(seenCount)
	);

	// Reference arithmetic of the instruction set.
	function automatic cpuPkg::wordT add8(input cpuPkg::wordT a, input cpuPkg::wordT b);
		return cpuPkg::wordT'((int'(a) + int'(b)) % 256); // Modulo 256.
	endfunction

	function automatic cpuPkg::wordT sub8(input cpuPkg::wordT a, input cpuPkg::wordT b);
		return cpuPkg::wordT'((int'(a) - int'(b) + 256) % 256);
	endfunction

	function automatic cpuPkg::wordT shl8(input cpuPkg::wordT a);
		return cpuPkg::wordT'((int'(a) * 2) % 256); // Bit 7 is lost.
	endfunction

	function automatic cpuPkg::wordT shr8(input cpuPkg::wordT a);
		return cpuPkg::wordT'(int'(a) / 2); // Zero enters at bit 7.
	endfunction

	task automatic emit(input cpuPkg::opcodeT op, input cpuPkg::wordT arg);
		prog[progLen] = {op, arg};
		progLen = progLen + 1;
	endtask

	// Store instruction plus the write it must produce.
	task automatic emitStore(input cpuPkg::opcodeT op, input cpuPkg::addrT addr,
		input logic [NAME_W-1:0] name, input cpuPkg::wordT data);
		emit(op, addr);
		expTab[nExp] = {name, addr, data};
		nExp = nExp + 1;
	endtask

	// Past the table the core spins on a jump to itself.
	function automatic cpuPkg::instrT fetch(input cpuPkg::addrT p);
		if (int'(p) < progLen) begin
			return prog[p];
		end
		return {`JMP, p};
	endfunction

	task automatic loadProgram();
		emit(`LDCA, 8'h5A);
		emitStore(`STA, 8'h10, "ldca_sta", 8'h5A);
		emit(`LDCB, 8'hA5);
		emitStore(`STB, 8'h11, "ldcb_stb", 8'hA5);
		emit(`LDCA, 8'h00);
		emit(`LDA, 8'h11); // A reloads B's byte.
		emitStore(`STA, 8'h12, "lda_reload", 8'hA5);
		emit(`LDB, 8'h10);
		emitStore(`STB, 8'h13, "ldb_reload", 8'h5A);
		emit(`ADDA, 8'h00);
		emitStore(`STA, 8'h20, "adda", add8(8'hA5, 8'h5A));
		emit(`ADDCA, 8'h02); // Wraps and sets carry.
		emitStore(`STA, 8'h21, "addca_wrap", add8(8'hFF, 8'h02));
		emit(`BACS, 8'd15);
		emit(`STA, 8'h2F); // Marker skipped.
		emit(`BACC, 8'd17);
		emitStore(`STA, 8'h22, "bacc_not_taken", 8'h01);
		emit(`ADDB, 8'h00);
		emitStore(`STB, 8'h23, "addb", add8(8'h5A, 8'h01));
		emit(`BBCC, 8'd21);
		emit(`STB, 8'h2F);
		emit(`BBCS, 8'd23);
		emitStore(`STB, 8'h24, "bbcs_not_taken", 8'h5B);
		emit(`SUBA, 8'h00); // Borrow into carry.
		emitStore(`STA, 8'h25, "suba_borrow", sub8(8'h01, 8'h5B));
		emit(`SUBCB, 8'h10);
		emitStore(`STB, 8'h26, "subcb", sub8(8'h5B, 8'h10));
		emit(`BBCS, 8'd29);
		emitStore(`STB, 8'h27, "bbcs_clear", 8'h4B);
		emit(`BACC, 8'd31);
		emitStore(`STA, 8'h28, "bacc_borrow", 8'hA6);
		emit(`ANDA, 8'h00);
		emitStore(`STA, 8'h30, "anda", 8'hA6 & 8'h4B);
		emit(`ORB, 8'h00);
		emitStore(`STB, 8'h31, "orb", 8'h4B | 8'h02);
		emit(`ASLA, 8'h00);
		emitStore(`STA, 8'h32, "asla", shl8(8'h02));
		emit(`LDCA, 8'h81);
		emit(`ASRA, 8'h00);
		emitStore(`STA, 8'h33, "asra_logical", shr8(8'h81));
		emit(`LDCA, 8'h80);
		emit(`ASLA, 8'h00); // Result zero.
		emit(`BAEQ, 8'd44);
		emit(`STA, 8'h2F);
		emit(`BANE, 8'd46);
		emitStore(`STA, 8'h34, "asla_zero", shl8(8'h80));
		emit(`BACS, 8'd48); // Carry kept through shifts.
		emit(`STA, 8'h2F);
		emit(`LDCA, 8'hF0);
		emit(`BAPL, 8'd51);
		emitStore(`STA, 8'h35, "bapl_not_taken", 8'hF0);
		emit(`BAMI, 8'd53);
		emit(`STA, 8'h2F);
		emit(`ANDCB, 8'h00); // B zero, A still negative.
		emit(`BAMI, 8'd56);
		emit(`STA, 8'h2F);
		emit(`BBEQ, 8'd58);
		emit(`STB, 8'h2F);
		emit(`BANE, 8'd60);
		emit(`STA, 8'h2F);
		emit(`BBNE, 8'd62);
		emitStore(`STB, 8'h36, "bbne_not_taken", 8'h00);
		emit(`BBPL, 8'd64);
		emit(`STB, 8'h2F);
		emit(`ORCB, 8'h80);
		emit(`BBMI, 8'd67);
		emit(`STB, 8'h2F);
		emit(`BBPL, 8'd69);
		emitStore(`STB, 8'h37, "bbpl_not_taken", 8'h80);
		emit(`BBEQ, 8'd71);
		emitStore(`STA, 8'h38, "bbeq_not_taken", 8'hF0);
		emit(`BAEQ, 8'd73);
		emitStore(`STB, 8'h39, "baeq_not_taken", 8'h80);
		emit(`BBNE, 8'd75);
		emit(`STB, 8'h2F);
		emit(`ADDCA, 8'h01);
		emit(`BACS, 8'd78); // No carry out.
		emitStore(`STA, 8'h3A, "bacs_not_taken", add8(8'hF0, 8'h01));
		emit(`SUBCB, 8'h81);
		emit(`BBCC, 8'd81);
		emitStore(`STB, 8'h3B, "bbcc_not_taken", sub8(8'h80, 8'h81));
		emit(`LDCA, 8'h7F);
		emit(`BAMI, 8'd84);
		emitStore(`STA, 8'h3C, "bami_not_taken", 8'h7F);
		emit(`BAPL, 8'd86);
		emit(`STA, 8'h2F);
		emit(`LDCB, 8'h01);
		emit(`BBMI, 8'd89);
		emitStore(`STB, 8'h3D, "bbmi_not_taken", 8'h01);
		emit(`JMP, 8'd91);
		emit(`STA, 8'h2F); // Never stored.
		emitStore(`STA, 8'h3E, "jmp_redirect", 8'h7F);
		emit(`BACC, 8'd94); // A carry clear since the last ADDCA.
		emit(`STA, 8'h2F);
		emit(`BBCS, 8'd96); // B still holds the SUBCB borrow.
		emit(`STB, 8'h2F);
		emitStore(`STB, 8'h3F, "bbcs_taken", 8'h01);
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

	always @(negedge clk) begin
		if (tableReady) begin
			instr = fetch(pc); // Program memory read.
		end
	end

	initial begin
		rstN = 1'b0;
		tableReady = 1'b0;
		progLen = 0;
		nExp = 0;
		loadProgram();
		instr = {`STA, 8'h2F}; // Store on the bus while reset is held.
		repeat (4) @(posedge clk);
		tableReady = 1'b1; // Fetch starts with the release of reset.
		@(negedge clk);
		rstN = 1'b1;
		wait (int'(pc) >= progLen); // Core reached the halt loop.
		@(posedge clk);
		@(negedge clk);
		missing = NUM_STORES - seenCount;
		if (missing > 0) begin
			$display("%0d expected stores never appeared", missing);
		end
		$display("errors %0d, missing %0d, stores seen %0d of %0d",
			errCount, missing, seenCount, NUM_STORES);
		if (errCount == 0 && missing == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog sized by program and store counts.
	initial begin
		wait (tableReady);
		timeoutNs = longint'(progLen + nExp + 20) * 100;
		#(timeoutNs);
		$display("timeout: program did not reach its end after %0d ns", timeoutNs);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" && verilator --binary --timing -Wno-fatal -f vlog.f --top-module cpuTb -o cpuSim && ./obj_dir/cpuSim | tee /dev/stderr | grep -q "Verification passed" && echo "run passed" || { echo "run failed"; exit 1; }

// File: verilog/accumulatorBank.sv
`timescale 1ns/1ps

module accumulatorBank (
	input logic clk,
	input logic rstN,
	input cpuPkg::ctrlT ctrl,
	input cpuPkg::wordT result,
	input cpuPkg::flagsT nextFlagsA,
	input cpuPkg::flagsT nextFlagsB,
	output cpuPkg::wordT accA,
	output cpuPkg::wordT accB,
	output cpuPkg::flagsT flagsA,
	output cpuPkg::flagsT flagsB
);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			accA <= '0;
			accB <= '0;
			flagsA <= '0;
			flagsB <= '0;
		end else begin
			if (ctrl.writeA) begin
				accA <= result;
			end
			if (ctrl.writeB) begin
				accB <= result;
			end
			if (ctrl.flagsA) begin
				flagsA <= nextFlagsA; // Own enable per flag set.
			end
			if (ctrl.flagsB) begin
				flagsB <= nextFlagsB;
			end
		end
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module alu (
	input cpuPkg::opcodeT opcode,
	input cpuPkg::wordT accA,
	input cpuPkg::wordT accB,
	input cpuPkg::wordT operand,
	input cpuPkg::wordT ramData,
	input cpuPkg::ctrlT ctrl,
	input logic isJump,
	input cpuPkg::flagsT flagsA,
	input cpuPkg::flagsT flagsB,
	output cpuPkg::wordT result,
	output cpuPkg::flagsT nextFlagsA,
	output cpuPkg::flagsT nextFlagsB,
	output logic branchTaken
);

	logic targetB; // Operation works on B.
	cpuPkg::wordT dst; // Target accumulator value.
	cpuPkg::wordT src; // Selected source operand.
	logic [`WORD_W:0] sum9; // Sum or difference with carry bit.
	logic carryUpd; // Add or subtract in progress.
	cpuPkg::flagsT newFlags; // Flags of the target after this op.

	assign targetB = ctrl.writeB | (opcode == `STB); // STB writes nothing but reads B.
	assign dst = targetB ? accB : accA;
	assign src = ctrl.useConst ? operand :
		ctrl.useMem ? ramData :
		targetB ? accA : accB; // Otherwise the other accumulator.

	always_comb begin
		result = '0;
		sum9 = '0;
		carryUpd = 1'b0;
		if (!isJump) begin // Jumps produce no data.
			case (opcode)
				`LDA, `LDB, `LDCA, `LDCB: result = src;
				`STA, `STB: result = dst; // Pass-through to RAM.
				`ADDA, `ADDB, `ADDCA, `ADDCB: begin
					sum9 = {1'b0, dst} + {1'b0, src};
					result = sum9[`WORD_W-1:0];
					carryUpd = 1'b1;
				end
				`SUBA, `SUBB, `SUBCA, `SUBCB: begin
					sum9 = {1'b0, dst} - {1'b0, src}; // Top bit is the borrow.
					result = sum9[`WORD_W-1:0];
					carryUpd = 1'b1;
				end
				`ANDA, `ANDB, `ANDCA, `ANDCB: result = dst & src;
				`ORA, `ORB, `ORCA, `ORCB: result = dst | src;
				`ASLA: result = dst << 1;
				`ASRA: result = dst >> 1; // Zero fills bit 7.
				default: result = '0;
			endcase
		end
	end

	// Flags follow the value being written now.
	always_comb begin
		newFlags.carry = targetB ? flagsB.carry : flagsA.carry;
		if (carryUpd) begin
			newFlags.carry = sum9[`WORD_W];
		end
		newFlags.zero = (result == '0);
		newFlags.negative = result[`WORD_W-1];
		nextFlagsA = ctrl.flagsA ? newFlags : flagsA; // Other side keeps its flags.
		nextFlagsB = ctrl.flagsB ? newFlags : flagsB;
	end

	always_comb begin
		branchTaken = 1'b0;
		if (isJump) begin
			case (opcode)
				`JMP: branchTaken = 1'b1;
				`BAEQ: branchTaken = flagsA.zero;
				`BANE: branchTaken = ~flagsA.zero;
				`BBEQ: branchTaken = flagsB.zero;
				`BBNE: branchTaken = ~flagsB.zero;
				`BACS: branchTaken = flagsA.carry;
				`BACC: branchTaken = ~flagsA.carry;
				`BBCS: branchTaken = flagsB.carry;
				`BBCC: branchTaken = ~flagsB.carry;
				`BAMI: branchTaken = flagsA.negative;
				`BAPL: branchTaken = ~flagsA.negative;
				`BBMI: branchTaken = flagsB.negative;
				`BBPL: branchTaken = ~flagsB.negative;
				default: branchTaken = 1'b0;
			endcase
		end
	end

endmodule

// File: verilog/controlUnit.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module controlUnit (
	input logic rstN,
	input cpuPkg::opcodeT opcode,
	output cpuPkg::ctrlT ctrl,
	output logic isJump
);

	always_comb begin
		ctrl = '0; // Nothing happens by default.
		isJump = 1'b0;
		if (rstN) begin // Held quiet during reset.
			case (opcode)
				`LDA: begin
					ctrl.writeA = 1'b1;
					ctrl.flagsA = 1'b1;
					ctrl.useMem = 1'b1; // Byte from RAM.
				end
				`LDB: begin
					ctrl.writeB = 1'b1;
					ctrl.flagsB = 1'b1;
					ctrl.useMem = 1'b1;
				end
				`LDCA: begin
					ctrl.writeA = 1'b1;
					ctrl.flagsA = 1'b1;
					ctrl.useConst = 1'b1; // Immediate byte.
				end
				`LDCB: begin
					ctrl.writeB = 1'b1;
					ctrl.flagsB = 1'b1;
					ctrl.useConst = 1'b1;
				end
				`STA, `STB: begin
					ctrl.memWrite = 1'b1; // Flags untouched by stores.
				end
				// A op B, and the shifts of A.
				`ADDA, `SUBA, `ANDA, `ORA, `ASLA, `ASRA: begin
					ctrl.writeA = 1'b1;
					ctrl.flagsA = 1'b1;
				end
				`ADDCA, `SUBCA, `ANDCA, `ORCA: begin
					ctrl.writeA = 1'b1;
					ctrl.flagsA = 1'b1;
					ctrl.useConst = 1'b1; // A op constant.
				end
				`ADDB, `SUBB, `ANDB, `ORB: begin
					ctrl.writeB = 1'b1; // B op A.
					ctrl.flagsB = 1'b1;
				end
				`ADDCB, `SUBCB, `ANDCB, `ORCB: begin
					ctrl.writeB = 1'b1;
					ctrl.flagsB = 1'b1;
					ctrl.useConst = 1'b1; // B op constant.
				end
				`JMP,
				`BAEQ, `BANE, `BBEQ, `BBNE,
				`BACS, `BACC, `BBCS, `BBCC,
				`BAMI, `BAPL, `BBMI, `BBPL: begin
					isJump = 1'b1; // Only pc may change.
				end
				default: begin
					ctrl = '0; // Unknown opcode acts as a no-op.
					isJump = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: verilog/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
	input logic clk,
	input logic rstN,
	input cpuPkg::instrT instr,
	output cpuPkg::addrT pc,
	output logic memWrite,
	output cpuPkg::addrT memAddr,
	output cpuPkg::wordT memWData
);

	cpuPkg::ctrlT ctrl; // Decoded strobes.
	logic isJump;
	cpuPkg::wordT accA;
	cpuPkg::wordT accB;
	cpuPkg::flagsT flagsA;
	cpuPkg::flagsT flagsB;
	cpuPkg::flagsT nextFlagsA;
	cpuPkg::flagsT nextFlagsB;
	cpuPkg::wordT result; // ALU output, also store data.
	cpuPkg::wordT ramData;
	logic branchTaken;

	assign memWrite = ctrl.memWrite; // Store port mirrors the RAM write.
	assign memAddr = instr.operand;
	assign memWData = result;

	controlUnit i_controlUnit (
		.rstN(rstN),
		.opcode(instr.opcode),
		.ctrl(ctrl),
		.isJump(isJump)
	);

	alu i_alu (
		.opcode(instr.opcode),
		.accA(accA),
		.accB(accB),
		.operand(instr.operand),
		.ramData(ramData),
		.ctrl(ctrl),
		.isJump(isJump),
		.flagsA(flagsA),
		.flagsB(flagsB),
		.result(result),
		.nextFlagsA(nextFlagsA),
		.nextFlagsB(nextFlagsB),
		.branchTaken(branchTaken)
	);

	accumulatorBank i_accumulatorBank (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.result(result),
		.nextFlagsA(nextFlagsA),
		.nextFlagsB(nextFlagsB),
		.accA(accA),
		.accB(accB),
		.flagsA(flagsA),
		.flagsB(flagsB)
	);

	programCounter i_programCounter (
		.clk(clk),
		.rstN(rstN),
		.branchTaken(branchTaken),
		.target(instr.operand), // Jump target field.
		.pc(pc)
	);

	dataRam i_dataRam (
		.clk(clk),
		.write(ctrl.memWrite),
		.addr(instr.operand),
		.wData(result),
		.rData(ramData)
	);

endmodule

// File: verilog/cpuPkg.sv
`include "cpu_cfg.svh"

package cpuPkg;

	typedef logic [`WORD_W-1:0] wordT; // Data byte.
	typedef logic [`ADDR_W-1:0] addrT; // RAM address or pc.
	typedef logic [`OPC_W-1:0] opcodeT; // Instruction opcode.

	// One instruction word, opcode in the upper bits.
	typedef struct packed {
		opcodeT opcode; // Operation.
		wordT operand; // Address, constant or jump target.
	} instrT;

	// Status of one accumulator.
	typedef struct packed {
		logic carry; // Carry out, or borrow after subtract.
		logic zero; // Last result was zero.
		logic negative; // Bit 7 of last result.
	} flagsT;

	// Decoded strobes.
	typedef struct packed {
		logic writeA; // Load result into A.
		logic writeB; // Load result into B.
		logic flagsA; // Update A flags.
		logic flagsB; // Update B flags.
		logic useConst; // Source is the operand field.
		logic useMem; // Source is RAM read data.
		logic memWrite; // Store into RAM.
	} ctrlT;

endpackage

// File: verilog/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define WORD_W 8 // Data path width.
`define ADDR_W 8 // Data address and pc width.
`define OPC_W 6 // Opcode field width.
`define MEM_DEPTH (1 << `ADDR_W) // Bytes of data RAM.

// Loads and stores.
`define LDA 6'h00 // A <= mem[operand].
`define LDB 6'h01 // B <= mem[operand].
`define LDCA 6'h02 // A <= constant.
`define LDCB 6'h03 // B <= constant.
`define STA 6'h04 // mem[operand] <= A.
`define STB 6'h05 // mem[operand] <= B.

// Arithmetic and logic, register or constant source.
`define ADDA 6'h06
`define ADDB 6'h07
`define ADDCA 6'h08
`define ADDCB 6'h09
`define SUBA 6'h0A
`define SUBB 6'h0B
`define SUBCA 6'h0C
`define SUBCB 6'h0D
`define ANDA 6'h0E
`define ANDB 6'h0F
`define ANDCA 6'h10
`define ANDCB 6'h11
`define ORA 6'h12
`define ORB 6'h13
`define ORCA 6'h14
`define ORCB 6'h15
`define ASLA 6'h16 // Shift A left.
`define ASRA 6'h17 // Logical shift A right.

// Control flow.
`define JMP 6'h18
`define BAEQ 6'h19
`define BANE 6'h1A
`define BBEQ 6'h1B
`define BBNE 6'h1C
`define BACS 6'h1D
`define BACC 6'h1E
`define BBCS 6'h1F
`define BBCC 6'h20
`define BAMI 6'h21
`define BAPL 6'h22
`define BBMI 6'h23
`define BBPL 6'h24

`endif

// File: verilog/dataRam.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module dataRam (
	input logic clk,
	input logic write,
	input cpuPkg::addrT addr,
	input cpuPkg::wordT wData,
	output cpuPkg::wordT rData
);

	cpuPkg::wordT mem [`MEM_DEPTH]; // Contents survive reset.

	assign rData = mem[addr]; // Read in the same cycle.

	always_ff @(posedge clk) begin
		if (write) begin
			mem[addr] <= wData;
		end
	end

endmodule

// File: verilog/programCounter.sv
`timescale 1ns/1ps

module programCounter (
	input logic clk,
	input logic rstN,
	input logic branchTaken,
	input cpuPkg::addrT target,
	output cpuPkg::addrT pc
);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0; // Start of program.
		end else if (branchTaken) begin
			pc <= target;
		end else begin
			pc <= pc + 1'b1; // Wraps from 255 to 0.
		end
	end

endmodule

// File: vlog.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/controlUnit.sv
verilog/alu.sv
verilog/accumulatorBank.sv
verilog/programCounter.sv
verilog/dataRam.sv
verilog/cpuCore.sv
bench/cpuChecker.sv
bench/cpuTb.sv
